/* common/graph_pkg.sv */
`default_nettype none

package graph_pkg;

localparam int mem_words = 1024;
localparam int word_idx_width = $clog2(mem_words);
localparam int addr_width = word_idx_width + 2; // byte address
localparam int data_width = 32;
localparam int len_width = 8;                   // beats minus one
localparam int burst_max = 64;

// header words that each hold a base in words
localparam logic [word_idx_width-1:0] hdr_edge_offset_idx = 3;
localparam logic [word_idx_width-1:0] hdr_neighbors_idx = 4;
localparam logic [word_idx_width-1:0] hdr_dist_idx = 5;

localparam int undo_entry_width = data_width + addr_width; // old value above address

endpackage

`default_nettype wire

/* common/task_pkg.sv */
`default_nettype none

package task_pkg;

localparam int task_ts_width = 32;     // candidate distance
localparam int task_locale_width = 16; // vertex id
localparam int task_ttype_width = 4;
localparam int task_args_width = 12;

localparam int task_width =
   task_args_width + task_ttype_width + task_locale_width + task_ts_width;

// field positions with args on top
localparam int ts_lsb = 0;
localparam int locale_lsb = ts_lsb + task_ts_width;
localparam int ttype_lsb = locale_lsb + task_locale_width;

localparam logic [task_ttype_width-1:0] ttype_relax = '0;

endpackage

`default_nettype wire

/* dv/tb_sssp_ref.svh */
`ifndef tb_sssp_ref_svh
`define tb_sssp_ref_svh

localparam int n_vertices = 24;
localparam int max_degree = 3;
localparam logic [31:0] dist_inf = 32'hffff_ffff;

int seed;
int degree [n_vertices];
int edge_dst [n_vertices][max_degree];
int edge_wt [n_vertices][max_degree];
logic [31:0] ref_dist [n_vertices];

// self loops and parallel edges are allowed
function automatic void build_graph();
   for (int v = 0; v < n_vertices; v++) begin
      degree[v] = $random(seed) & 3;
      for (int e = 0; e < max_degree; e++) begin
         edge_dst[v][e] = ($random(seed) & 32'h7fff_ffff) % n_vertices;
         edge_wt[v][e] = ($random(seed) & 32'h7fff_ffff) % 15 + 1; // 1 to 15
      end
   end
endfunction

// O(n^2) Dijkstra from vertex 0 that returns how many vertices it reaches
function automatic int compute_dijkstra();
   logic done [n_vertices];
   logic [31:0] cand;
   int best;
   int reach;
   reach = 0;
   for (int v = 0; v < n_vertices; v++) begin
      ref_dist[v] = dist_inf;
      done[v] = 1'b0;
   end
   ref_dist[0] = '0;
   for (int k = 0; k < n_vertices; k++) begin
      best = -1;
      for (int v = 0; v < n_vertices; v++) begin
         if (!done[v] && ref_dist[v] != dist_inf &&
             (best < 0 || ref_dist[v] < ref_dist[best])) begin
            best = v;
         end
      end
      if (best >= 0) begin
         done[best] = 1'b1;
         reach++;
         for (int e = 0; e < degree[best]; e++) begin
            cand = ref_dist[best] + 32'(edge_wt[best][e]);
            if (cand < ref_dist[edge_dst[best][e]]) ref_dist[edge_dst[best][e]] = cand;
         end
      end
   end
   return reach;
endfunction

`endif

/* dv/tb_sssp.sv */
`default_nettype none

module tb_sssp;

timeunit 1ns;
timeprecision 100ps;

`include "tb_sssp_ref.svh"

localparam int n_graphs = 3;
localparam int undo_depth = 64;
localparam int timeout_cycles = n_graphs * 6000 + 2000; // load, run, reseed, readback
// non-zero bases that move per graph, so results depend on the header fetch
localparam int eoff_bases [n_graphs] = '{32, 200, 600};
localparam int nbr_bases [n_graphs] = '{96, 400, 800};
localparam int dist_bases [n_graphs] = '{320, 700, 64};

logic clk, rstn, seed_valid, seed_ready, host_we, undo_out_valid, undo_out_ready, tile_idle;
logic [task_pkg::task_width-1:0] seed_task;
logic [graph_pkg::word_idx_width-1:0] host_addr;
logic [graph_pkg::data_width-1:0] host_wdata, host_rdata;
logic [graph_pkg::undo_entry_width-1:0] undo_out_entry;
logic [$clog2(undo_depth):0] undo_count;
logic [graph_pkg::undo_entry_width-1:0] undo_seen [$];
int mismatch_count, error_count, cycle_count;

sssp_tile #(.undo_depth(undo_depth)) u_sssp_tile (
   .clk, .rstn, .seed_valid, .seed_task, .seed_ready,
   .host_we, .host_addr, .host_wdata, .host_rdata,
   .undo_out_valid, .undo_out_entry, .undo_out_ready, .undo_count, .tile_idle
);

initial begin
   clk = 1'b0;
   forever #2 clk = ~clk;
end

always @(negedge clk) begin
   if (undo_out_valid && undo_out_ready) undo_seen.push_back(undo_out_entry); // host drain
end

task automatic apply_reset();
   @(posedge clk);
   #1;
   rstn = 1'b0;
   repeat (8) @(posedge clk);
   #1;
   rstn = 1'b1;
endtask

task automatic write_word(input int addr, input logic [31:0] data);
   @(posedge clk);
   #1;
   host_we = 1'b1;
   host_addr = graph_pkg::word_idx_width'(addr);
   host_wdata = data;
endtask

task automatic read_word(input int addr, output logic [31:0] data);
   @(posedge clk);
   #1;
   host_addr = graph_pkg::word_idx_width'(addr);
   @(posedge clk);
   @(negedge clk);
   data = host_rdata; // one cycle read latency
endtask

task automatic load_graph(input int g);
   int next_edge;
   next_edge = 0;
   for (int i = 0; i < 3; i++) write_word(i, '0);
   write_word(graph_pkg::hdr_edge_offset_idx, eoff_bases[g]);
   write_word(graph_pkg::hdr_neighbors_idx, nbr_bases[g]);
   write_word(graph_pkg::hdr_dist_idx, dist_bases[g]);
   for (int v = 0; v <= n_vertices; v++) begin
      write_word(eoff_bases[g] + v, next_edge);
      if (v < n_vertices) begin
         for (int e = 0; e < degree[v]; e++) begin
            write_word(nbr_bases[g] + 2 * (next_edge + e), edge_dst[v][e]);
            write_word(nbr_bases[g] + 2 * (next_edge + e) + 1, edge_wt[v][e]);
         end
         next_edge += degree[v];
      end
   end
   for (int v = 0; v < n_vertices; v++) write_word(dist_bases[g] + v, dist_inf);
   @(posedge clk);
   #1;
   host_we = 1'b0;
endtask

task automatic seed_vertex(input int v, input logic [31:0] ts);
   @(posedge clk);
   #1;
   seed_task = '0;
   seed_task[task_pkg::ts_lsb +: task_pkg::task_ts_width] = ts;
   seed_task[task_pkg::locale_lsb +: task_pkg::task_locale_width] =
      task_pkg::task_locale_width'(v);
   seed_task[task_pkg::ttype_lsb +: task_pkg::task_ttype_width] = task_pkg::ttype_relax;
   seed_valid = 1'b1;
   @(negedge clk);
   while (!seed_ready) @(negedge clk);
   @(posedge clk);
   #1;
   seed_valid = 1'b0;
endtask

task automatic wait_tile_idle();
   int streak;
   streak = 0;
   while (streak < 4) begin
      @(negedge clk);
      streak = tile_idle ? streak + 1 : 0;
   end
endtask

task automatic expect_idle(input string when);
   @(negedge clk);
   if (!tile_idle) begin
      error_count++;
      $display("tile is not idle %s", when);
   end
   if (undo_out_valid || undo_count != 0) begin
      mismatch_count++;
      $display("mismatch undo_count %s: got %h expected 0", when, undo_count);
   end
endtask

task automatic compare_distances(input int g);
   logic [31:0] got;
   for (int v = 0; v < n_vertices; v++) begin
      read_word(dist_bases[g] + v, got);
      if (got !== ref_dist[v]) begin
         mismatch_count++;
         $display("mismatch dist[%0d] graph %0d: got %h expected %h", v, g, got, ref_dist[v]);
      end
   end
endtask

task automatic audit_undo(input int g, input int n_reach, input int n_edges);
   logic [graph_pkg::data_width-1:0] old_value;
   logic [graph_pkg::addr_width-1:0] addr;
   int v;
   foreach (undo_seen[i]) begin
      addr = undo_seen[i][graph_pkg::addr_width-1:0];
      old_value = undo_seen[i][graph_pkg::undo_entry_width-1:graph_pkg::addr_width];
      v = int'(addr[graph_pkg::addr_width-1:2]) - dist_bases[g];
      if (addr[1:0] != 2'b00 || v < 0 || v >= n_vertices) begin
         error_count++;
         $display("undo entry %0d has address %h outside the distance array", i, addr);
      end else if (!(old_value > ref_dist[v])) begin
         error_count++;
         $display("undo entry %0d for vertex %0d holds %h, not above final %h",
                  i, v, old_value, ref_dist[v]);
      end
   end
   if (undo_seen.size() < n_reach || undo_seen.size() > n_edges + 1) begin
      error_count++;
      $display("graph %0d logged %0d undo entries, expected %0d to %0d",
               g, undo_seen.size(), n_reach, n_edges + 1);
   end
endtask

initial begin
   cycle_count = 0;
   while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
   end
   $display("timeout: tile still busy after %0d cycles", timeout_cycles);
   $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
   $display("CHECKS FAILED");
   $finish;
end

initial begin
   int n_reach;
   int n_edges;
   int last_reach;
   int logged;
   rstn = 1'b0;
   seed_valid = 1'b0;
   seed_task = '0;
   host_we = 1'b0;
   host_addr = '0;
   host_wdata = '0;
   undo_out_ready = 1'b1;
   mismatch_count = 0;
   error_count = 0;
   seed = 32'hc26d_1be0;
   for (int g = 0; g < n_graphs; g++) begin
      apply_reset();
      expect_idle("after reset");
      build_graph();
      n_reach = compute_dijkstra();
      n_edges = 0;
      last_reach = 0;
      for (int v = 0; v < n_vertices; v++) begin
         n_edges += degree[v];
         if (ref_dist[v] != dist_inf) last_reach = v;
      end
      load_graph(g);
      undo_seen.delete();
      seed_vertex(0, '0);
      wait_tile_idle();
      expect_idle("after run");
      compare_distances(g);
      audit_undo(g, n_reach, n_edges);
      // finished vertex again with a worse distance
      logged = undo_seen.size();
      seed_vertex(last_reach, ref_dist[last_reach] + 32'd1 + 32'($random(seed) & 7));
      wait_tile_idle();
      expect_idle("after reseed");
      compare_distances(g);
      if (undo_seen.size() != logged) begin
         error_count++;
         $display("reseed of vertex %0d added %0d undo entries", last_reach,
                  undo_seen.size() - logged);
      end
   end
   $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
   if (mismatch_count == 0 && error_count == 0) begin
      $display("ALL CHECKS PASSED");
   end else begin
      $display("CHECKS FAILED");
   end
   $finish;
end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+dv
common/task_pkg.sv
common/graph_pkg.sv
hdl/task_queue.sv
sssp_core/graph_mem.sv
sssp_core/sssp_core.sv
hdl/undo_log.sv
hdl/sssp_tile.sv
dv/tb_sssp.sv

/* hdl/sssp_tile.sv */
`default_nettype none

module sssp_tile #(
   parameter int queue_depth = 32,
   parameter int undo_depth = 64
) (
   input  wire                                     clk,
   input  wire                                     rstn,
   input  wire                                     seed_valid,
   input  wire  [task_pkg::task_width-1:0]         seed_task,
   output logic                                    seed_ready,
   input  wire                                     host_we,
   input  wire  [graph_pkg::word_idx_width-1:0]    host_addr,
   input  wire  [graph_pkg::data_width-1:0]        host_wdata,
   output logic [graph_pkg::data_width-1:0]        host_rdata,
   output logic                                    undo_out_valid,
   output logic [graph_pkg::undo_entry_width-1:0]  undo_out_entry,
   input  wire                                     undo_out_ready,
   output logic [$clog2(undo_depth):0]             undo_count,
   output logic                                    tile_idle
);

logic push_valid, push_ready, pop_valid, pop_ready, queue_empty;
logic [task_pkg::task_width-1:0] push_task, pop_task, child_task;
logic child_valid, core_idle;
logic ar_valid, ar_ready, r_valid, r_last, r_ready;
logic [graph_pkg::addr_width-1:0] ar_addr, wr_addr;
logic [graph_pkg::len_width-1:0] ar_len;
logic [graph_pkg::data_width-1:0] r_data, wr_data;
logic wr_valid, wr_ready, wr_done, wr_pending;
logic undo_valid, undo_ready;
logic [graph_pkg::undo_entry_width-1:0] undo_entry;

// children win the push port and seeds fill idle cycles
assign push_valid = child_valid | seed_valid;
assign push_task = child_valid ? child_task : seed_task;
assign seed_ready = push_ready & ~child_valid;

assign tile_idle = queue_empty & core_idle & ~wr_valid & ~wr_pending & ~seed_valid;

always_ff @(posedge clk) begin
   if (!rstn) begin
      wr_pending <= 1'b0;
   end else if (wr_valid && wr_ready) begin
      wr_pending <= 1'b1;
   end else if (wr_done) begin
      wr_pending <= 1'b0;
   end
end

task_queue #(.queue_depth(queue_depth)) u_task_queue (
   .clk, .rstn, .push_valid, .push_task, .push_ready,
   .pop_valid, .pop_task, .pop_ready, .empty(queue_empty)
);

sssp_core u_sssp_core (
   .clk, .rstn, .pop_valid, .pop_task, .pop_ready,
   .child_valid, .child_task, .child_ready(push_ready),
   .ar_valid, .ar_addr, .ar_len, .ar_ready, .r_valid, .r_data, .r_last, .r_ready,
   .wr_valid, .wr_addr, .wr_data, .wr_ready, .wr_done,
   .undo_valid, .undo_entry, .undo_ready, .core_idle
);

graph_mem u_graph_mem (
   .clk, .rstn, .ar_valid, .ar_addr, .ar_len, .ar_ready,
   .r_valid, .r_data, .r_last, .r_ready,
   .wr_valid, .wr_addr, .wr_data, .wr_ready, .wr_done,
   .host_we, .host_addr, .host_wdata, .host_rdata
);

undo_log #(.undo_depth(undo_depth)) u_undo_log (
   .clk, .rstn, .in_valid(undo_valid), .in_entry(undo_entry), .in_ready(undo_ready),
   .out_valid(undo_out_valid), .out_entry(undo_out_entry), .out_ready(undo_out_ready),
   .count(undo_count)
);

endmodule

`default_nettype wire

/* hdl/task_queue.sv */
`default_nettype none

module task_queue #(
   parameter int queue_depth = 32
) (
   input  wire                               clk,
   input  wire                               rstn,
   input  wire                               push_valid,
   input  wire  [task_pkg::task_width-1:0]   push_task,
   output logic                              push_ready,
   output logic                              pop_valid,
   output logic [task_pkg::task_width-1:0]   pop_task,
   input  wire                               pop_ready,
   output logic                              empty
);

localparam int idx_width = $clog2(queue_depth);
localparam int ts_width = task_pkg::task_ts_width;

logic [task_pkg::task_width-1:0] slots [queue_depth];
logic [queue_depth-1:0] valid, valid_next;
logic [idx_width-1:0] min_idx, min_next, free_idx;
logic [ts_width-1:0] best_ts, slot_ts;
logic found, push_fire, pop_fire;

assign empty = ~|valid;
assign push_ready = ~&valid;
assign pop_valid = ~empty;
assign pop_task = slots[min_idx];
assign push_fire = push_valid & push_ready;
assign pop_fire = pop_valid & pop_ready;

always_comb begin
   free_idx = '0;
   for (int i = queue_depth - 1; i >= 0; i--) begin
      if (!valid[i]) begin
         free_idx = idx_width'(i); // lowest free slot wins
      end
   end
end

always_comb begin
   valid_next = valid;
   if (pop_fire) begin
      valid_next[min_idx] = 1'b0;
   end
   if (push_fire) begin
      valid_next[free_idx] = 1'b1;
   end
end

// min search over the post-update contents, so the head is ready next cycle
always_comb begin
   found = 1'b0;
   best_ts = '1;
   min_next = '0;
   slot_ts = '0;
   for (int i = 0; i < queue_depth; i++) begin
      slot_ts = (push_fire && free_idx == idx_width'(i)) ?
                push_task[task_pkg::ts_lsb +: ts_width] :
                slots[i][task_pkg::ts_lsb +: ts_width];
      if (valid_next[i] && (!found || slot_ts < best_ts)) begin // ties keep lower slot
         found = 1'b1;
         best_ts = slot_ts;
         min_next = idx_width'(i);
      end
   end
end

always_ff @(posedge clk) begin
   if (!rstn) begin
      valid <= '0;
      min_idx <= '0;
   end else begin
      valid <= valid_next;
      min_idx <= min_next;
   end
end

always_ff @(posedge clk) begin
   if (push_fire) begin
      slots[free_idx] <= push_task;
   end
end

// a push that meets a full queue is held until a slot frees up
a_full_push_held: assert property (@(posedge clk) disable iff (!rstn)
   push_valid && !push_ready |=> push_valid);

endmodule

`default_nettype wire

/* hdl/undo_log.sv */
`default_nettype none

module undo_log #(
   parameter int undo_depth = 64
) (
   input  wire                                     clk,
   input  wire                                     rstn,
   input  wire                                     in_valid,
   input  wire  [graph_pkg::undo_entry_width-1:0]  in_entry,
   output logic                                    in_ready,
   output logic                                    out_valid,
   output logic [graph_pkg::undo_entry_width-1:0]  out_entry,
   input  wire                                     out_ready,
   output logic [$clog2(undo_depth):0]             count
);

localparam int ptr_width = $clog2(undo_depth);

logic [graph_pkg::undo_entry_width-1:0] entries [undo_depth];
logic [ptr_width-1:0] wr_ptr, rd_ptr;
logic in_fire, out_fire;

assign in_ready = (count != undo_depth);
assign out_valid = (count != '0);
assign out_entry = entries[rd_ptr];
assign in_fire = in_valid & in_ready;
assign out_fire = out_valid & out_ready;

always_ff @(posedge clk) begin
   if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
   end else begin
      if (in_fire) wr_ptr <= wr_ptr + 1'b1; // wraps on power-of-two depth
      if (out_fire) rd_ptr <= rd_ptr + 1'b1;
      count <= count + in_fire - out_fire;
   end
end

always_ff @(posedge clk) begin
   if (in_fire) begin
      entries[wr_ptr] <= in_entry;
   end
end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the SSSP tile testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sssp -f filelist.f -o sim_sssp

./obj_dir/sim_sssp > sim.log 2>&1
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* sssp_core/graph_mem.sv */
`default_nettype none

module graph_mem (
   input  wire                                  clk,
   input  wire                                  rstn,
   input  wire                                  ar_valid,
   input  wire  [graph_pkg::addr_width-1:0]     ar_addr,
   input  wire  [graph_pkg::len_width-1:0]      ar_len,
   output logic                                 ar_ready,
   output logic                                 r_valid,
   output logic [graph_pkg::data_width-1:0]     r_data,
   output logic                                 r_last,
   input  wire                                  r_ready,
   input  wire                                  wr_valid,
   input  wire  [graph_pkg::addr_width-1:0]     wr_addr,
   input  wire  [graph_pkg::data_width-1:0]     wr_data,
   output logic                                 wr_ready,
   output logic                                 wr_done,
   input  wire                                  host_we,
   input  wire  [graph_pkg::word_idx_width-1:0] host_addr,
   input  wire  [graph_pkg::data_width-1:0]     host_wdata,
   output logic [graph_pkg::data_width-1:0]     host_rdata
);

logic [graph_pkg::data_width-1:0] mem [graph_pkg::mem_words];
logic [graph_pkg::word_idx_width-1:0] rd_ptr;
logic [graph_pkg::len_width-1:0] beats_left;
logic busy;

assign ar_ready = ~busy;
assign r_valid = busy;
assign r_data = mem[rd_ptr];
assign r_last = (beats_left == '0);
assign wr_ready = 1'b1;

always_ff @(posedge clk) begin
   if (!rstn) begin
      busy <= 1'b0;
      wr_done <= 1'b0;
   end else begin
      wr_done <= wr_valid; // one cycle after the write
      if (ar_valid && ar_ready) begin
         busy <= 1'b1;
      end else if (r_valid && r_ready && r_last) begin
         busy <= 1'b0;
      end
   end
end

always_ff @(posedge clk) begin
   if (ar_valid && ar_ready) begin
      rd_ptr <= ar_addr[graph_pkg::addr_width-1:2];
      beats_left <= ar_len;
   end else if (r_valid && r_ready) begin
      rd_ptr <= rd_ptr + 1'b1;
      beats_left <= beats_left - 1'b1;
   end
end

always_ff @(posedge clk) begin
   if (host_we) begin
      mem[host_addr] <= host_wdata; // host load
   end else if (wr_valid) begin
      mem[wr_addr[graph_pkg::addr_width-1:2]] <= wr_data;
   end
   host_rdata <= mem[host_addr];
end

endmodule

`default_nettype wire

/* sssp_core/sssp_core.sv */
`default_nettype none

module sssp_core (
   input  wire                                     clk,
   input  wire                                     rstn,
   input  wire                                     pop_valid,
   input  wire  [task_pkg::task_width-1:0]         pop_task,
   output logic                                    pop_ready,
   output logic                                    child_valid,
   output logic [task_pkg::task_width-1:0]         child_task,
   input  wire                                     child_ready,
   output logic                                    ar_valid,
   output logic [graph_pkg::addr_width-1:0]        ar_addr,
   output logic [graph_pkg::len_width-1:0]         ar_len,
   input  wire                                     ar_ready,
   input  wire                                     r_valid,
   input  wire  [graph_pkg::data_width-1:0]        r_data,
   input  wire                                     r_last,
   output logic                                    r_ready,
   output logic                                    wr_valid,
   output logic [graph_pkg::addr_width-1:0]        wr_addr,
   output logic [graph_pkg::data_width-1:0]        wr_data,
   input  wire                                     wr_ready,
   input  wire                                     wr_done,
   output logic                                    undo_valid,
   output logic [graph_pkg::undo_entry_width-1:0]  undo_entry,
   input  wire                                     undo_ready,
   output logic                                    core_idle
);

localparam int aw = graph_pkg::addr_width;
localparam int iw = graph_pkg::word_idx_width;

typedef enum logic [3:0] {
   s_idle, s_base_rd, s_base_wait, s_dist_rd, s_dist_wait, s_eoff_rd, s_eoff_wait,
   s_nbr_rd, s_nbr_wait, s_wt_wait, s_write_wait
} core_state_t;
typedef enum logic [1:0] {w_idle, w_undo, w_write, w_done} write_state_t;

core_state_t state, state_next;
write_state_t wstate, wstate_next;
logic initialized, wr_begin;
logic [1:0] base_sel;
logic [iw-1:0] hdr_idx;
logic [aw-1:0] base_eoff, base_nbr, base_dist, dist_addr;
logic [task_pkg::task_locale_width-1:0] vertex_id, neighbor;
logic [task_pkg::task_ts_width-1:0] vertex_dist;
logic [graph_pkg::data_width-1:0] old_dist, edge_start, edge_end, nbr_beats;

assign core_idle = (state == s_idle);
assign pop_ready = (state == s_idle);
assign dist_addr = base_dist + {vertex_id[iw-1:0], 2'b00};
assign nbr_beats = (edge_end - edge_start) << 1; // id and weight per edge

assign r_ready = (state == s_base_wait) | (state == s_dist_wait) |
                 (state == s_eoff_wait) | (state == s_nbr_wait) |
                 ((state == s_wt_wait) & child_ready); // stall burst behind child push

always_comb begin
   case (base_sel)
      2'd0: hdr_idx = graph_pkg::hdr_edge_offset_idx;
      2'd1: hdr_idx = graph_pkg::hdr_neighbors_idx;
      default: hdr_idx = graph_pkg::hdr_dist_idx;
   endcase
end

always_comb begin
   child_task = '0; // args stay zero
   child_task[task_pkg::ts_lsb +: task_pkg::task_ts_width] = r_data + vertex_dist;
   child_task[task_pkg::locale_lsb +: task_pkg::task_locale_width] = neighbor;
   child_task[task_pkg::ttype_lsb +: task_pkg::task_ttype_width] = task_pkg::ttype_relax;
end

always_comb begin
   state_next = state;
   ar_valid = 1'b0;
   ar_addr = '0;
   ar_len = '0; // single beat
   wr_begin = 1'b0;
   child_valid = 1'b0;
   case (state)
      s_idle: begin
         if (pop_valid) begin
            state_next = initialized ? s_dist_rd : s_base_rd;
         end
      end
      s_base_rd: begin
         ar_valid = 1'b1;
         ar_addr = {hdr_idx, 2'b00};
         if (ar_ready) begin
            state_next = s_base_wait;
         end
      end
      s_base_wait: begin
         if (r_valid) begin
            state_next = (base_sel == 2'd2) ? s_dist_rd : s_base_rd;
         end
      end
      s_dist_rd: begin
         ar_valid = 1'b1;
         ar_addr = dist_addr;
         if (ar_ready) begin
            state_next = s_dist_wait;
         end
      end
      s_dist_wait: begin
         if (r_valid) begin
            if (vertex_dist < r_data) begin
               wr_begin = 1'b1; // write runs beside the edge reads
               state_next = s_eoff_rd;
            end else begin
               state_next = s_idle;
            end
         end
      end
      s_eoff_rd: begin
         ar_valid = 1'b1;
         ar_addr = base_eoff + {vertex_id[iw-1:0], 2'b00};
         ar_len = 1; // start and end offsets
         if (ar_ready) begin
            state_next = s_eoff_wait;
         end
      end
      s_eoff_wait: begin
         if (r_valid && r_last) begin
            state_next = s_nbr_rd;
         end
      end
      s_nbr_rd: begin
         if (edge_start == edge_end) begin
            state_next = s_write_wait;
         end else begin
            ar_valid = 1'b1;
            ar_addr = base_nbr + {edge_start[iw-2:0], 3'b000};
            ar_len = graph_pkg::len_width'(nbr_beats - 1);
            if (ar_ready) begin
               state_next = s_nbr_wait;
            end
         end
      end
      s_nbr_wait: begin
         if (r_valid) begin
            state_next = s_wt_wait;
         end
      end
      s_wt_wait: begin
         child_valid = r_valid;
         if (r_valid && child_ready) begin
            state_next = r_last ? s_write_wait : s_nbr_wait;
         end
      end
      s_write_wait: begin
         if (wstate == w_idle) begin
            state_next = s_idle;
         end
      end
      default: state_next = s_idle;
   endcase
end

always_comb begin
   wstate_next = wstate;
   case (wstate)
      w_idle:  if (wr_begin) wstate_next = w_undo;
      w_undo:  if (undo_ready) wstate_next = w_write;
      w_write: if (wr_ready) wstate_next = w_done;
      default: if (wr_done) wstate_next = w_idle;
   endcase
end

assign undo_valid = (wstate == w_undo);
assign undo_entry = {old_dist, dist_addr};
assign wr_valid = (wstate == w_write);
assign wr_addr = dist_addr;
assign wr_data = vertex_dist;

always_ff @(posedge clk) begin
   if (!rstn) begin
      state <= s_idle;
      wstate <= w_idle;
      initialized <= 1'b0;
      base_sel <= '0;
   end else begin
      state <= state_next;
      wstate <= wstate_next;
      if (state == s_base_rd) begin
         initialized <= 1'b1;
      end
      if (state == s_base_wait && r_valid) begin
         base_sel <= base_sel + 2'd1;
      end
   end
end

always_ff @(posedge clk) begin
   if (pop_valid && pop_ready) begin
      vertex_id <= pop_task[task_pkg::locale_lsb +: task_pkg::task_locale_width];
      vertex_dist <= pop_task[task_pkg::ts_lsb +: task_pkg::task_ts_width];
   end
   if (r_valid && r_ready) begin
      case (state)
         s_base_wait: begin
            if (base_sel == 2'd0) base_eoff <= {r_data[iw-1:0], 2'b00};
            if (base_sel == 2'd1) base_nbr <= {r_data[iw-1:0], 2'b00};
            if (base_sel == 2'd2) base_dist <= {r_data[iw-1:0], 2'b00};
         end
         s_dist_wait: old_dist <= r_data;
         s_eoff_wait: begin
            if (r_last) edge_end <= r_data;
            else edge_start <= r_data;
         end
         s_nbr_wait: neighbor <= r_data[task_pkg::task_locale_width-1:0];
         default: ;
      endcase
   end
end

a_burst_len: assert property (@(posedge clk) disable iff (!rstn)
   ar_valid |-> ar_len < graph_pkg::burst_max &&
                (state != s_nbr_rd || nbr_beats <= graph_pkg::burst_max));

// the previous task waits for its write, so a new one never overlaps it
a_write_not_busy: assert property (@(posedge clk) disable iff (!rstn)
   wr_begin |-> wstate == w_idle);

endmodule

`default_nettype wire
